/* sim/cache_system_asserts.sv */
module cache_system_asserts import cache_pkg::*; (
	input logic        clk,
	input logic        rst_n,
	input logic        rd_in,
	input logic        wr_in,
	input logic        done,
	input logic        mem_rd,
	input logic        mem_wr,
	input logic        err,
	input ctrl_state_t state
);
	timeunit 1ns;
	timeprecision 1ps;

	int violations = 0; // Failure count read at the end of the run

	property p_no_rd_wr;
		@(posedge clk) disable iff (!rst_n) !(mem_rd && mem_wr);
	endproperty

	property p_err_low;
		@(posedge clk) disable iff (!rst_n) !err;
	endproperty

	// Accepted request leaves idle at once
	property p_done_drops;
		@(posedge clk) disable iff (!rst_n) (done && (rd_in || wr_in)) |=> !done;
	endproperty

	property p_wr_in_wb;
		@(posedge clk) disable iff (!rst_n) mem_wr |-> (state inside {wb0, wb1, wb2, wb3});
	endproperty

	a_no_rd_wr: assert property (p_no_rd_wr) else begin
		violations++;
		$error("mem_rd and mem_wr high in the same cycle");
	end

	a_err_low: assert property (p_err_low) else begin
		violations++;
		$error("err raised, controller reached an illegal state");
	end

	a_done_drops: assert property (p_done_drops) else begin
		violations++;
		$error("done still high after an accepted request");
	end

	a_wr_in_wb: assert property (p_wr_in_wb) else begin
		violations++;
		$error("mem_wr high outside the writeback states");
	end

endmodule

/* sim/cache_system_tb.sv */
`include "cache_macros.svh"

module cache_system_tb import cache_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 30;

	logic  clk;
	logic  rst_n;
	addr_t addr_in;
	word_t data_in;
	logic  rd_in;
	logic  wr_in;
	word_t data_out;
	logic  done;
	logic  err;

	int    checks;
	int    errors;
	int    violations;
	bit    hung; // Set on any timeout so later requests are skipped
	bit    line_valid [`NUM_LINES];
	bit    line_dirty [`NUM_LINES];
	tag_t  line_tag [`NUM_LINES];
	word_t ref_mem [addr_t]; // Keyed by even byte address

	clk_gen #(.PERIOD(20)) i_clk_gen (.clk(clk));

	cache_system i_cache_system (
		.clk      (clk),
		.rst_n    (rst_n),
		.addr_in  (addr_in),
		.data_in  (data_in),
		.rd_in    (rd_in),
		.wr_in    (wr_in),
		.data_out (data_out),
		.done     (done),
		.err      (err)
	);

	bind cache_controller cache_system_asserts ctrl_asserts (
		.clk    (clk),
		.rst_n  (rst_n),
		.rd_in  (rd_in),
		.wr_in  (wr_in),
		.done   (done),
		.mem_rd (mem_rd),
		.mem_wr (mem_wr),
		.err    (err),
		.state  (state)
	);

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (hung) begin
			return;
		end
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (hung) begin
			return;
		end
		checks++;
		if (got != exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Hit 2 cycles, clean miss 8 and dirty miss 12 plus one for a write miss
	function automatic int predict_latency(input addr_t addr, input bit is_wr);
		index_t idx;
		tag_t   tag;
		int     lat;
		idx = addr[`OFFSET_W +: `INDEX_W];
		tag = addr[`ADDR_W-1 -: `TAG_W];
		if (line_valid[idx] && line_tag[idx] == tag) begin
			lat = 2;
		end else begin
			lat = (line_valid[idx] && line_dirty[idx]) ? 12 : 8;
			if (is_wr) begin
				lat = lat + 1;
			end
			line_valid[idx] = 1'b1;
			line_tag[idx]   = tag;
			line_dirty[idx] = 1'b0; // Fresh fill is clean
		end
		if (is_wr) begin
			line_dirty[idx] = 1'b1;
		end
		return lat;
	endfunction

	function automatic word_t expected_word(input addr_t addr);
		addr_t key;
		key = {addr[`ADDR_W-1:1], 1'b0};
		if (ref_mem.exists(key)) begin
			return ref_mem[key];
		end
		return '0; // Memory starts at zero
	endfunction

	task automatic wait_idle();
		if (hung) begin
			return;
		end
		for (int i = 0; i < TIMEOUT; i++) begin
			@(negedge clk);
			if (done) begin
				return;
			end
		end
		hung = 1'b1;
		$display("Timeout: done stayed low for %0d cycles before a request", TIMEOUT);
	endtask

	// Counts cycles after the sampling edge until done is back
	task automatic wait_done(output int cycles);
		cycles = 0;
		if (hung) begin
			return;
		end
		while (cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (done) begin
				return;
			end
		end
		hung = 1'b1;
		$display("Timeout: request did not complete within %0d cycles", TIMEOUT);
	endtask

	task automatic do_read(input addr_t addr, output word_t data, output int cycles);
		cycles = 0;
		data   = '0;
		wait_idle();
		if (hung) begin
			return;
		end
		@(posedge clk);
		addr_in <= addr;
		rd_in   <= 1'b1;
		@(posedge clk);
		rd_in <= 1'b0;
		wait_done(cycles);
		data = data_out; // Held while done is high
	endtask

	task automatic do_write(input addr_t addr, input word_t data, output int cycles);
		cycles = 0;
		wait_idle();
		if (hung) begin
			return;
		end
		@(posedge clk);
		addr_in <= addr;
		data_in <= data; // Kept until the next write and used again after a fill
		wr_in   <= 1'b1;
		@(posedge clk);
		wr_in <= 1'b0;
		wait_done(cycles);
	endtask

	task automatic read_check(input addr_t addr, output int cycles);
		word_t data;
		int    exp_lat;
		exp_lat = predict_latency(addr, 1'b0);
		do_read(addr, data, cycles);
		check_latency("read latency", cycles, exp_lat);
		check_word("data_out", data, expected_word(addr));
	endtask

	task automatic write_check(input addr_t addr, input word_t data, output int cycles);
		int exp_lat;
		exp_lat = predict_latency(addr, 1'b1);
		do_write(addr, data, cycles);
		ref_mem[{addr[`ADDR_W-1:1], 1'b0}] = data;
		check_latency("write latency", cycles, exp_lat);
	endtask

	task automatic reset_state();
		int lat;
		@(negedge clk);
		check_flag("done", done, 1'b1);
		check_flag("err", err, 1'b0);
		read_check(16'h1234, lat);
	endtask

	task automatic read_miss_then_hit();
		int lat;
		read_check(16'h0040, lat);
		check_latency("miss latency", lat, 8);
		read_check(16'h0042, lat);
		check_latency("hit latency", lat, 2);
	endtask

	task automatic write_miss_then_read();
		int lat;
		write_check(16'h0a10, 16'hbeef, lat);
		check_latency("write miss latency", lat, 9);
		read_check(16'h0a10, lat);
		read_check(16'h0a12, lat);
		read_check(16'h0a14, lat);
		read_check(16'h0a16, lat);
	endtask

	// Index 20 under tags 0x11 and 0x22
	task automatic dirty_eviction();
		int lat;
		write_check(16'h11a2, 16'hc0de, lat);
		read_check(16'h22a2, lat);
		check_latency("dirty miss latency", lat, 12);
		read_check(16'h11a2, lat);
	endtask

	task automatic random_mix();
		addr_t addr;
		int    lat;
		for (int i = 0; i < 60; i++) begin
			addr = {tag_t'(8'h30 + $urandom % 3), index_t'(4 + $urandom % 2),
				offset_t'(2 * ($urandom % 4))};
			if ($urandom % 2) begin
				write_check(addr, word_t'($urandom), lat);
			end else begin
				read_check(addr, lat);
			end
			if (!hung && !(lat inside {2, 8, 9, 12, 13})) begin
				errors++;
				$display("Latency of %0d cycles is none of the allowed values", lat);
			end
		end
	endtask

	task automatic report_test(input string name, input int start);
		$display("test %s: %0d errors", name, errors - start);
	endtask

	initial begin
		int start;
		void'($urandom(90));
		rst_n   = 1'b0;
		rd_in   = 1'b0;
		wr_in   = 1'b0;
		addr_in = '0;
		data_in = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		start = errors;
		reset_state();
		report_test("reset", start);
		start = errors;
		read_miss_then_hit();
		report_test("read miss then hit", start);
		start = errors;
		write_miss_then_read();
		report_test("write miss", start);
		start = errors;
		dirty_eviction();
		report_test("dirty eviction", start);
		start = errors;
		random_mix();
		report_test("random", start);

		violations = i_cache_system.i_cache_controller.ctrl_asserts.violations;
		$display("checks: %0d, errors: %0d, assertion failures: %0d, timeout: %0d",
			checks, errors, violations, hung);
		if (errors == 0 && violations == 0 && !hung) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* sim/clk_gen.sv */
module clk_gen #(
	parameter int PERIOD = 20
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
	end

	always begin
		#(PERIOD / 2) clk = ~clk; // Half period per phase
	end

endmodule

/* tb.f */
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_store.sv
verilog/cache_array.sv
verilog/bank_memory.sv
verilog/cache_controller.sv
verilog/cache_system.sv
sim/clk_gen.sv
sim/cache_system_asserts.sv
sim/cache_system_tb.sv

/* verilog/bank_memory.sv */
`include "cache_macros.svh"

module bank_memory import cache_pkg::*; (
	input  logic  clk,
	input  addr_t mem_addr,
	input  logic  mem_rd,
	input  logic  mem_wr,
	input  word_t mem_wdata,
	output word_t mem_rdata
);

	localparam int SEL_W = $clog2(`NUM_BANKS);

	logic [SEL_W-1:0]              bank_sel;
	logic [$clog2(`BANK_DEPTH)-1:0] bank_addr;
	word_t                         bank_rdata [`NUM_BANKS];
	word_t                         rd_data [`MEM_LATENCY];
	logic [`MEM_LATENCY-1:0]       rd_valid = '0;

	assign bank_sel  = mem_addr[SEL_W:1];       // Interleave on word address
	assign bank_addr = mem_addr[`ADDR_W-1:SEL_W+1];

	for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
		cache_store #(.entry_t(word_t), .DEPTH(`BANK_DEPTH)) bank (
			.clk   (clk),
			.we    (mem_wr && (bank_sel == SEL_W'(b))),
			.waddr (bank_addr),
			.wdata (mem_wdata),
			.raddr (bank_addr),
			.rdata (bank_rdata[b])
		);
	end

	// Read pipeline accepting one new request per cycle
	always_ff @(posedge clk) begin
		rd_valid <= {rd_valid[`MEM_LATENCY-2:0], mem_rd};
		if (mem_rd) begin
			rd_data[0] <= bank_rdata[bank_sel];
		end
		for (int i = 1; i < `MEM_LATENCY; i++) begin
			if (rd_valid[i-1]) begin
				rd_data[i] <= rd_data[i-1];
			end
		end
	end

	// Zero when no read is returning
	assign mem_rdata = rd_valid[`MEM_LATENCY-1] ? rd_data[`MEM_LATENCY-1] : '0;

endmodule

/* verilog/cache_array.sv */
`include "cache_macros.svh"

module cache_array import cache_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t cache_addr,
	input  logic  comp,
	input  logic  write,
	input  logic  data_src,
	input  word_t cpu_wdata,
	input  word_t mem_rdata,
	output logic  hit,
	output logic  valid,
	output logic  dirty,
	output tag_t  tag_out,
	output word_t rdata
);

	localparam int DATA_DEPTH = `NUM_LINES * `LINE_WORDS;

	tag_t                          addr_tag;
	index_t                        addr_index;
	logic [$clog2(DATA_DEPTH)-1:0] data_addr;
	tag_entry_t                    entry_rd;
	tag_entry_t                    entry_wr;
	word_t                         wdata;
	logic                          tag_we;
	logic                          data_we;
	logic [`NUM_LINES-1:0]         valid_bits;

	assign addr_tag   = cache_addr[`ADDR_W-1 -: `TAG_W];
	assign addr_index = cache_addr[`OFFSET_W +: `INDEX_W];
	assign data_addr  = {addr_index, cache_addr[`OFFSET_W-1:1]}; // Word within line

	cache_store #(.entry_t(tag_entry_t), .DEPTH(`NUM_LINES)) tag_store (
		.clk   (clk),
		.we    (tag_we),
		.waddr (addr_index),
		.wdata (entry_wr),
		.raddr (addr_index),
		.rdata (entry_rd)
	);

	cache_store #(.entry_t(word_t), .DEPTH(DATA_DEPTH)) data_store (
		.clk   (clk),
		.we    (data_we),
		.waddr (data_addr),
		.wdata (wdata),
		.raddr (data_addr),
		.rdata (rdata)
	);

	assign hit     = (entry_rd.tag == addr_tag); // Tag match only
	assign valid   = valid_bits[addr_index];
	assign dirty   = entry_rd.dirty;
	assign tag_out = entry_rd.tag;

	assign wdata = data_src ? mem_rdata : cpu_wdata;

	always_comb begin
		tag_we   = 1'b0;
		data_we  = 1'b0;
		entry_wr = entry_rd;
		if (write) begin
			if (comp) begin
				if (valid && hit) begin // CPU store on a hit
					tag_we         = 1'b1;
					data_we        = 1'b1;
					entry_wr.dirty = 1'b1;
				end
			end else begin // Line fill
				tag_we   = 1'b1;
				data_we  = 1'b1;
				entry_wr = '{valid: 1'b1, dirty: 1'b0, tag: addr_tag};
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
		end else if (write && !comp) begin
			valid_bits[addr_index] <= 1'b1;
		end
	end

endmodule

/* verilog/cache_controller.sv */
`include "cache_macros.svh"

module cache_controller import cache_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t addr_in,
	input  logic  rd_in,
	input  logic  wr_in,
	input  logic  hit,
	input  logic  valid,
	input  logic  dirty,
	input  tag_t  tag_out,
	output addr_t cache_addr,
	output logic  comp,
	output logic  write,
	output logic  data_src,
	output addr_t mem_addr,
	output logic  mem_rd,
	output logic  mem_wr,
	output logic  done,
	output logic  err
);

	ctrl_state_t state;
	ctrl_state_t next_state;
	addr_t       addr_q;
	logic        is_wr_q;
	logic        accept;
	logic        illegal;
	logic        tag_src; // Writeback uses the stored tag
	offset_t     cache_off;
	offset_t     mem_off;
	tag_t        cpu_tag;
	index_t      cpu_index;

	assign accept    = (state == idle) && (rd_in || wr_in);
	assign cpu_tag   = addr_q[`ADDR_W-1 -: `TAG_W];
	assign cpu_index = addr_q[`OFFSET_W +: `INDEX_W];

	// Address and request kind held for the whole miss sequence
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_q  <= '0;
			is_wr_q <= 1'b0;
		end else if (accept) begin
			addr_q  <= addr_in;
			is_wr_q <= !rd_in; // Read wins
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			err   <= 1'b0;
		end else begin
			state <= next_state;
			if (illegal) begin
				err <= 1'b1; // Sticky
			end
		end
	end

	always_comb begin
		next_state = idle;
		illegal    = 1'b0;
		done       = 1'b0;
		comp       = 1'b0;
		write      = 1'b0;
		data_src   = 1'b0;
		mem_rd     = 1'b0;
		mem_wr     = 1'b0;
		tag_src    = 1'b0;
		cache_off  = addr_q[`OFFSET_W-1:0];
		mem_off    = '0;
		case (state)
			idle: begin
				done = 1'b1;
				if (rd_in) begin
					next_state = cmp_rd;
				end else if (wr_in) begin
					next_state = cmp_wr;
				end
			end
			cmp_rd, cmp_wr: begin
				comp  = 1'b1;
				write = (state == cmp_wr);
				if (hit && valid) begin
					next_state = idle;
				end else if (valid && dirty) begin
					next_state = wb0; // Evict dirty line first
				end else begin
					next_state = req0;
				end
			end
			wb0, wb1, wb2, wb3: begin
				mem_wr     = 1'b1;
				tag_src    = 1'b1;
				cache_off  = offset_t'((state - wb0) * 2);
				mem_off    = cache_off;
				next_state = ctrl_state_t'(state + 4'd1); // wb3 rolls into req0
			end
			req0, req1: begin
				mem_rd     = 1'b1;
				mem_off    = offset_t'((state - req0) * 2);
				next_state = ctrl_state_t'(state + 4'd1);
			end
			req2_fill0, req3_fill1: begin
				mem_rd     = 1'b1;
				mem_off    = offset_t'((state - req0) * 2);
				write      = 1'b1;
				data_src   = 1'b1;
				cache_off  = offset_t'((state - req2_fill0) * 2);
				next_state = ctrl_state_t'(state + 4'd1);
			end
			fill2: begin
				write      = 1'b1;
				data_src   = 1'b1;
				cache_off  = 3'd4;
				next_state = fill3;
			end
			fill3: begin
				write      = 1'b1;
				data_src   = 1'b1;
				cache_off  = 3'd6;
				next_state = is_wr_q ? cmp_wr : idle; // Store the word now
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

	assign cache_addr = {cpu_tag, cpu_index, cache_off};
	assign mem_addr   = {(tag_src ? tag_out : cpu_tag), cpu_index, mem_off};

endmodule

/* verilog/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// CPU side widths
`define ADDR_W 16
`define WORD_W 16

// Address split into tag, index and byte offset
`define OFFSET_W 3
`define INDEX_W 5
`define TAG_W 8

// Cache geometry
`define NUM_LINES (1 << `INDEX_W)
`define LINE_WORDS (1 << (`OFFSET_W - 1))

// Main memory
`define MEM_LATENCY 2
`define NUM_BANKS 4
`define BANK_DEPTH ((1 << (`ADDR_W - 1)) / `NUM_BANKS)

`endif

/* verilog/cache_pkg.sv */
`include "cache_macros.svh"

package cache_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`TAG_W-1:0] tag_t;
	typedef logic [`INDEX_W-1:0] index_t;
	typedef logic [`OFFSET_W-1:0] offset_t;

	// One entry per cache line
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} tag_entry_t;

	// Codes 13 to 15 are unused and flagged as errors
	typedef enum logic [3:0] {
		idle       = 4'd0,
		cmp_rd     = 4'd1,
		cmp_wr     = 4'd2,
		wb0        = 4'd3,
		wb1        = 4'd4,
		wb2        = 4'd5,
		wb3        = 4'd6,
		req0       = 4'd7,
		req1       = 4'd8,
		req2_fill0 = 4'd9,
		req3_fill1 = 4'd10,
		fill2      = 4'd11,
		fill3      = 4'd12
	} ctrl_state_t;

endpackage

/* verilog/cache_store.sv */
`include "cache_macros.svh"

module cache_store import cache_pkg::*; #(
	parameter type entry_t = word_t,
	parameter int DEPTH = 32
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  entry_t                   wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output entry_t                   rdata
);

	entry_t mem [DEPTH];

	// Contents start at zero in simulation and in the FPGA bitstream
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	assign rdata = mem[raddr]; // Asynchronous read

endmodule

/* verilog/cache_system.sv */
`include "cache_macros.svh"

module cache_system (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`ADDR_W-1:0] addr_in,
	input  logic [`WORD_W-1:0] data_in,
	input  logic               rd_in,
	input  logic               wr_in,
	output logic [`WORD_W-1:0] data_out,
	output logic               done,
	output logic               err
);

	logic [`ADDR_W-1:0] cache_addr;
	logic [`ADDR_W-1:0] mem_addr;
	logic [`WORD_W-1:0] mem_rdata;
	logic [`TAG_W-1:0]  tag_out;
	logic               comp;
	logic               write;
	logic               data_src;
	logic               hit;
	logic               valid;
	logic               dirty;
	logic               mem_rd;
	logic               mem_wr;

	cache_controller i_cache_controller (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr_in    (addr_in),
		.rd_in      (rd_in),
		.wr_in      (wr_in),
		.hit        (hit),
		.valid      (valid),
		.dirty      (dirty),
		.tag_out    (tag_out),
		.cache_addr (cache_addr),
		.comp       (comp),
		.write      (write),
		.data_src   (data_src),
		.mem_addr   (mem_addr),
		.mem_rd     (mem_rd),
		.mem_wr     (mem_wr),
		.done       (done),
		.err        (err)
	);

	cache_array i_cache_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.cache_addr (cache_addr),
		.comp       (comp),
		.write      (write),
		.data_src   (data_src),
		.cpu_wdata  (data_in),
		.mem_rdata  (mem_rdata),
		.hit        (hit),
		.valid      (valid),
		.dirty      (dirty),
		.tag_out    (tag_out),
		.rdata      (data_out)  // Also the writeback data
	);

	bank_memory i_bank_memory (
		.clk       (clk),
		.mem_addr  (mem_addr),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_wdata (data_out),
		.mem_rdata (mem_rdata)
	);

endmodule
